// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = line_follower_tb
FILELIST = project.f
LOG      = sim.log
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "simulation did not complete"; exit 1)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== project.f ====
rtl/line_pkg.sv
rtl/adc_serial_reader.sv
rtl/sample_fifo.sv
rtl/line_steering.sv
rtl/line_follower_top.sv
test/tb_clock_gen.sv
test/line_follower_asserts.sv
test/line_follower_tb.sv

// ==== rtl/adc_serial_reader.sv ====
`timescale 1ns/1ps

module adc_serial_reader #(
   parameter int SCK_HALF = line_pkg::SCK_HALF_DEFAULT
) (
   input  logic                  clk_50M,
   input  logic                  i_rst,
   input  logic                  i_adc_dout,
   output logic                  o_adc_cs_n,
   output logic                  o_adc_sck,
   output logic                  o_adc_din,
   output logic                  o_smp_valid,
   output line_pkg::adc_sample_t o_smp,
   input  logic                  i_smp_ready
);

   import line_pkg::*;

   localparam int DIV_W = (SCK_HALF > 1) ? $clog2(SCK_HALF) : 1;

   logic [DIV_W-1:0]    div_cnt;
   logic                tick;
   logic [4:0]          cyc;
   logic [2:0]          cur_addr;
   logic [2:0]          prev_addr;
   logic                have_prev;
   logic                last_rise;
   logic [ADC_BITS-1:0] shift_q;

   // channel order 5, 6, 7
   function automatic logic [2:0] next_addr(input logic [2:0] addr);
      case (addr)
         CH_LEFT:   return CH_CENTRE;
         CH_CENTRE: return CH_RIGHT;
         default:   return CH_LEFT;
      endcase
   endfunction

   ////////////////////////////////////////
   // sck half period enable
   ////////////////////////////////////////

   assign tick = ~o_adc_cs_n && (div_cnt == DIV_W'(SCK_HALF - 1));

   always_ff @(posedge clk_50M)
   begin
      if (i_rst || o_adc_cs_n || tick)
         div_cnt <= '0;
      else
         div_cnt <= div_cnt + 1'b1;
   end

   ////////////////////////////////////////
   // frame sequencing
   ////////////////////////////////////////

   // a frame opens with the falling edge of cycle 1
   // and closes half a period after the rising edge of cycle 16
   always_ff @(posedge clk_50M)
   begin
      if (i_rst)
      begin
         o_adc_cs_n <= 1'b1;
         o_adc_sck  <= 1'b1;
         o_adc_din  <= 1'b0;
         cyc        <= '0;
         cur_addr   <= CH_LEFT;
         prev_addr  <= CH_LEFT;
         have_prev  <= 1'b0;
         last_rise  <= 1'b0;
      end
      else
      begin
         last_rise <= 1'b0;
         if (o_adc_cs_n)
         begin
            // wait here while the last sample is not taken
            if (!o_smp_valid)
            begin
               o_adc_cs_n <= 1'b0;
               o_adc_sck  <= 1'b0;
               o_adc_din  <= 1'b0;
               cyc        <= 5'd1;
            end
         end
         else if (tick)
         begin
            if (!o_adc_sck)
            begin
               o_adc_sck <= 1'b1;
               last_rise <= (cyc == 5'd16);
            end
            else if (cyc == 5'd16)
            begin
               o_adc_cs_n <= 1'b1;
               o_adc_din  <= 1'b0;
               // data for this address comes back next frame
               prev_addr  <= cur_addr;
               cur_addr   <= next_addr(cur_addr);
               have_prev  <= 1'b1;
            end
            else
            begin
               o_adc_sck <= 1'b0;
               cyc       <= cyc + 5'd1;
               // address bits go out on cycles 3 to 5, msb first
               case (cyc)
                  5'd2:    o_adc_din <= cur_addr[2];
                  5'd3:    o_adc_din <= cur_addr[1];
                  5'd4:    o_adc_din <= cur_addr[0];
                  default: o_adc_din <= 1'b0;
               endcase
            end
         end
      end
   end

   ////////////////////////////////////////
   // data capture and output
   ////////////////////////////////////////

   always_ff @(posedge clk_50M)
   begin
      if (tick && !o_adc_sck && (cyc >= 5'd5))
         shift_q <= {shift_q[ADC_BITS-2:0], i_adc_dout};
      if (last_rise)
      begin
         o_smp.ch   <= prev_addr;
         o_smp.data <= shift_q;
      end
   end

   // first frame after reset carries no valid data
   always_ff @(posedge clk_50M)
   begin
      if (i_rst)
         o_smp_valid <= 1'b0;
      else if (last_rise && have_prev)
         o_smp_valid <= 1'b1;
      else if (i_smp_ready)
         o_smp_valid <= 1'b0;
   end

endmodule

// ==== rtl/line_follower_top.sv ====
`timescale 1ns/1ps

module line_follower_top #(
   parameter int SCK_HALF   = line_pkg::SCK_HALF_DEFAULT,
   parameter int DEPTH      = 4,
   parameter int THRESHOLD  = line_pkg::THRESHOLD_DEFAULT,
   parameter int PWM_PERIOD = line_pkg::PWM_PERIOD_DEFAULT,
   parameter int DUTY_PCT   = line_pkg::DUTY_PCT_DEFAULT,
   parameter int HOLDOFF    = line_pkg::HOLDOFF_DEFAULT
) (
   input  logic                 clk_50M,
   input  logic                 i_rst,
   input  logic                 i_adc_dout,
   input  logic                 i_hold,
   output logic                 o_adc_cs_n,
   output logic                 o_adc_din,
   output logic                 o_adc_sck,
   output line_pkg::motor_cmd_t o_motor,
   output logic                 o_enable_a,
   output logic                 o_enable_b,
   output logic                 o_node_pulse
);

   import line_pkg::*;

   // reader to fifo
   logic        smp_valid;
   adc_sample_t smp;
   logic        smp_ready;

   // fifo to steering
   logic        fifo_valid;
   adc_sample_t fifo_data;
   logic        fifo_ready;

   adc_serial_reader #(
      .SCK_HALF    (SCK_HALF)
   ) adc_serial_reader_inst (
      .clk_50M     (clk_50M),
      .i_rst       (i_rst),
      .i_adc_dout  (i_adc_dout),
      .o_adc_cs_n  (o_adc_cs_n),
      .o_adc_sck   (o_adc_sck),
      .o_adc_din   (o_adc_din),
      .o_smp_valid (smp_valid),
      .o_smp       (smp),
      .i_smp_ready (smp_ready)
   );

   sample_fifo #(
      .DEPTH   (DEPTH)
   ) sample_fifo_inst (
      .clk_50M (clk_50M),
      .i_rst   (i_rst),
      .i_valid (smp_valid),
      .i_data  (smp),
      .o_ready (smp_ready),
      .o_valid (fifo_valid),
      .o_data  (fifo_data),
      .i_ready (fifo_ready)
   );

   line_steering #(
      .THRESHOLD    (THRESHOLD),
      .PWM_PERIOD   (PWM_PERIOD),
      .DUTY_PCT     (DUTY_PCT),
      .HOLDOFF      (HOLDOFF)
   ) line_steering_inst (
      .clk_50M      (clk_50M),
      .i_rst        (i_rst),
      .i_hold       (i_hold),
      .i_valid      (fifo_valid),
      .i_data       (fifo_data),
      .o_ready      (fifo_ready),
      .o_motor      (o_motor),
      .o_enable_a   (o_enable_a),
      .o_enable_b   (o_enable_b),
      .o_node_pulse (o_node_pulse)
   );

endmodule

// ==== rtl/line_pkg.sv ====
package line_pkg;

   ////////////////////////////////////////
   // sample path
   ////////////////////////////////////////

   localparam int ADC_BITS = 12;

   // one converted sample, tagged with its channel
   typedef struct packed {
      logic [2:0]          ch;
      logic [ADC_BITS-1:0] data;
   } adc_sample_t;

   // line sensor channels on the ADC128S022
   localparam logic [2:0] CH_LEFT   = 3'd5;
   localparam logic [2:0] CH_CENTRE = 3'd6;
   localparam logic [2:0] CH_RIGHT  = 3'd7;

   ////////////////////////////////////////
   // motor side
   ////////////////////////////////////////

   // H-bridge inputs, motor A then motor B
   typedef struct packed {
      logic in_a1;
      logic in_a2;
      logic in_b1;
      logic in_b2;
   } motor_cmd_t;

   // thresholded line sensors
   typedef struct packed {
      logic left;
      logic centre;
      logic right;
   } sensor_t;

   // defaults for the top level, 50 MHz board clock
   localparam int SCK_HALF_DEFAULT   = 10;
   localparam int THRESHOLD_DEFAULT  = 250;
   localparam int PWM_PERIOD_DEFAULT = 25000;
   localparam int DUTY_PCT_DEFAULT   = 45;
   localparam int HOLDOFF_DEFAULT    = 20000000;

endpackage

// ==== rtl/line_steering.sv ====
`timescale 1ns/1ps

module line_steering #(
   parameter int THRESHOLD  = line_pkg::THRESHOLD_DEFAULT,
   parameter int PWM_PERIOD = line_pkg::PWM_PERIOD_DEFAULT,
   parameter int DUTY_PCT   = line_pkg::DUTY_PCT_DEFAULT,
   parameter int HOLDOFF    = line_pkg::HOLDOFF_DEFAULT
) (
   input  logic                  clk_50M,
   input  logic                  i_rst,
   input  logic                  i_hold,
   input  logic                  i_valid,
   input  line_pkg::adc_sample_t i_data,
   output logic                  o_ready,
   output line_pkg::motor_cmd_t  o_motor,
   output logic                  o_enable_a,
   output logic                  o_enable_b,
   output logic                  o_node_pulse
);

   import line_pkg::*;

   localparam int DUTY_CNT = DUTY_PCT * PWM_PERIOD / 100;
   localparam int PWM_W    = (PWM_PERIOD > 1) ? $clog2(PWM_PERIOD) : 1;
   localparam int HOLD_W   = (HOLDOFF > 0) ? $clog2(HOLDOFF + 1) : 1;

   // drive modes, stop is the state out of reset
   localparam logic [1:0] MODE_STOP     = 2'd0;
   localparam logic [1:0] MODE_LEFT     = 2'd1;
   localparam logic [1:0] MODE_RIGHT    = 2'd2;
   localparam logic [1:0] MODE_STRAIGHT = 2'd3;

   sensor_t           sens;
   logic              accept;
   logic              above;
   logic              upd_motor;
   logic [1:0]        mode;
   logic [PWM_W-1:0]  pwm_cnt;
   logic              pwm_on;
   logic [HOLD_W-1:0] hold_cnt;
   logic              node_now;

   assign o_ready = ~i_hold;
   assign accept  = i_valid && o_ready;
   assign above   = (i_data.data > ADC_BITS'(THRESHOLD));

   ////////////////////////////////////////
   // sensors and drive mode
   ////////////////////////////////////////

   always_ff @(posedge clk_50M)
   begin
      if (i_rst)
      begin
         sens      <= '0;
         upd_motor <= 1'b0;
         mode      <= MODE_STOP;
      end
      else
      begin
         upd_motor <= accept && (i_data.ch == CH_RIGHT);
         if (accept)
         begin
            case (i_data.ch)
               CH_LEFT:   sens.left   <= above;
               CH_CENTRE: sens.centre <= above;
               CH_RIGHT:  sens.right  <= above;
               default:   sens        <= sens;
            endcase
         end
         // new mode once a full 5-6-7 round is in
         if (upd_motor)
         begin
            if (sens.centre)
               mode <= MODE_STRAIGHT;
            else if (sens.left && !sens.right)
               mode <= MODE_LEFT;
            else if (sens.right && !sens.left)
               mode <= MODE_RIGHT;
         end
      end
   end

   ////////////////////////////////////////
   // pwm and motor outputs
   ////////////////////////////////////////

   always_ff @(posedge clk_50M)
   begin
      if (i_rst || (pwm_cnt == PWM_W'(PWM_PERIOD - 1)))
         pwm_cnt <= '0;
      else
         pwm_cnt <= pwm_cnt + 1'b1;
   end

   assign pwm_on = (int'(pwm_cnt) < DUTY_CNT);

   // inner wheel is slowed by the pwm on a turn
   always_comb
   begin
      if (i_hold)
         o_motor = '1;
      else
      begin
         case (mode)
            MODE_LEFT:     o_motor = '{in_a1: pwm_on, in_a2: 1'b0, in_b1: 1'b1, in_b2: 1'b0};
            MODE_RIGHT:    o_motor = '{in_a1: 1'b1, in_a2: 1'b0, in_b1: pwm_on, in_b2: 1'b0};
            MODE_STRAIGHT: o_motor = '{in_a1: 1'b1, in_a2: 1'b0, in_b1: 1'b1, in_b2: 1'b0};
            default:       o_motor = '0;
         endcase
      end
   end

   assign o_enable_a = ~i_hold;
   assign o_enable_b = ~i_hold;

   ////////////////////////////////////////
   // node detector
   ////////////////////////////////////////

   assign node_now = sens.centre && (sens.left || sens.right);

   always_ff @(posedge clk_50M)
   begin
      if (i_rst)
      begin
         o_node_pulse <= 1'b0;
         hold_cnt     <= '0;
      end
      else
      begin
         o_node_pulse <= 1'b0;
         if (hold_cnt != '0)
            hold_cnt <= hold_cnt - 1'b1;
         else if (node_now)
         begin
            o_node_pulse <= 1'b1;
            hold_cnt     <= HOLD_W'(HOLDOFF);
         end
      end
   end

endmodule

// ==== rtl/sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo #(
   parameter int DEPTH = 4
) (
   input  logic                  clk_50M,
   input  logic                  i_rst,
   input  logic                  i_valid,
   input  line_pkg::adc_sample_t i_data,
   output logic                  o_ready,
   output logic                  o_valid,
   output line_pkg::adc_sample_t o_data,
   input  logic                  i_ready
);

   import line_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   adc_sample_t      mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   assign o_ready = (count != CNT_W'(DEPTH));
   assign o_valid = (count != '0);
   assign o_data  = mem[rd_ptr];

   assign push = i_valid && o_ready;
   assign pop  = o_valid && i_ready;

   always_ff @(posedge clk_50M)
   begin
      if (push)
         mem[wr_ptr] <= i_data;
   end

   // pointers wrap at DEPTH, so DEPTH need not be a power of two
   always_ff @(posedge clk_50M)
   begin
      if (i_rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

endmodule

// ==== test/line_follower_asserts.sv ====
`timescale 1ns/1ps

module line_follower_asserts (
   input logic                  clk_50M,
   input logic                  i_rst,
   input logic                  o_adc_cs_n,
   input logic                  o_adc_sck,
   input logic                  o_adc_din,
   input logic                  o_smp_valid,
   input line_pkg::adc_sample_t o_smp,
   input logic                  i_smp_ready,
   input logic [4:0]            cyc
);

   import line_pkg::*;

   int         fail_cnt = 0;
   logic [5:0] rise_cnt;

   // sck rising edges within the current frame
   always_ff @(posedge clk_50M)
   begin
      if (i_rst || $fell(o_adc_cs_n))
         rise_cnt <= '0;
      else if ($rose(o_adc_sck) && !o_adc_cs_n)
         rise_cnt <= rise_cnt + 6'd1;
   end

   sck_in_frame: assert property (@(posedge clk_50M) disable iff (i_rst)
      $changed(o_adc_sck) |-> !o_adc_cs_n)
      else
      begin
         $error("sck moved while cs_n high");
         fail_cnt++;
      end

   frame_len: assert property (@(posedge clk_50M) disable iff (i_rst)
      $rose(o_adc_cs_n) |-> (rise_cnt == 6'd16))
      else
      begin
         $error("frame not 16 sck periods");
         fail_cnt++;
      end

   din_window: assert property (@(posedge clk_50M) disable iff (i_rst)
      ((cyc < 5'd3) || (cyc > 5'd5)) |-> !o_adc_din)
      else
      begin
         $error("din high outside address cycles");
         fail_cnt++;
      end

   valid_hold: assert property (@(posedge clk_50M) disable iff (i_rst)
      (o_smp_valid && !i_smp_ready) |=> (o_smp_valid && $stable(o_smp)))
      else
      begin
         $error("sample dropped or changed before ready");
         fail_cnt++;
      end

endmodule

bind adc_serial_reader line_follower_asserts asserts_inst (
   .clk_50M     (clk_50M),
   .i_rst       (i_rst),
   .o_adc_cs_n  (o_adc_cs_n),
   .o_adc_sck   (o_adc_sck),
   .o_adc_din   (o_adc_din),
   .o_smp_valid (o_smp_valid),
   .o_smp       (o_smp),
   .i_smp_ready (i_smp_ready),
   .cyc         (cyc)
);

// ==== test/line_follower_tb.sv ====
`timescale 1ns/1ps

module line_follower_tb;

   import line_pkg::*;

   localparam int SCK_HALF   = 2;
   localparam int DEPTH      = 4;
   localparam int PWM_PERIOD = 100;
   localparam int HOLDOFF    = 500;
   localparam int DUTY_CNT   = DUTY_PCT_DEFAULT * PWM_PERIOD / 100;
   localparam int FRAME_CLKS = 32 * SCK_HALF + 4;
   localparam longint WATCHDOG_NS = 64'(200 * FRAME_CLKS + 10 * HOLDOFF) * 20;

   // expected command with a mask of the pwm-driven bits
   typedef struct packed {
      motor_cmd_t cmd;
      motor_cmd_t pwm;
   } exp_cmd_t;

   logic       clk_50M;
   logic       i_rst;
   logic       i_adc_dout;
   logic       i_hold;
   logic       o_adc_cs_n;
   logic       o_adc_din;
   logic       o_adc_sck;
   logic       o_enable_a;
   logic       o_enable_b;
   logic       o_node_pulse;
   motor_cmd_t o_motor;

   logic [ADC_BITS-1:0] chan_val [8];
   logic [2:0]          dec_addr;
   logic [2:0]          ret_ch;
   logic [2:0]          addr_log [$];
   int                  fall_cnt = 0;
   int                  frame_cnt = 0;
   int                  node_cnt = 0;
   int                  errors = 0;
   int                  checks = 0;
   exp_cmd_t            exp_now;
   bit                  chk_motor = 0;
   bit                  chk_hold = 0;

   tb_clock_gen #(.HALF_NS(10), .RST_CYCLES(2)) clock_inst (.clk_50M(clk_50M), .o_rst(i_rst));

   line_follower_top #(
      .SCK_HALF(SCK_HALF), .DEPTH(DEPTH), .THRESHOLD(THRESHOLD_DEFAULT),
      .PWM_PERIOD(PWM_PERIOD), .DUTY_PCT(DUTY_PCT_DEFAULT), .HOLDOFF(HOLDOFF)
   ) line_follower_top_inst (
      .clk_50M(clk_50M), .i_rst(i_rst), .i_adc_dout(i_adc_dout), .i_hold(i_hold),
      .o_adc_cs_n(o_adc_cs_n), .o_adc_din(o_adc_din), .o_adc_sck(o_adc_sck),
      .o_motor(o_motor), .o_enable_a(o_enable_a), .o_enable_b(o_enable_b),
      .o_node_pulse(o_node_pulse)
   );

   ////////////////////////////////////////
   // serial adc model
   ////////////////////////////////////////

   // dout moves on falling sck with zeros for cycles 1 to 4 then 12 bits
   always @(negedge o_adc_sck)
   begin
      #1;
      if (o_adc_cs_n === 1'b0)
      begin
         fall_cnt++;
         if (fall_cnt >= 5 && fall_cnt <= 16)
            i_adc_dout = chan_val[ret_ch][16 - fall_cnt];
         else
            i_adc_dout = 1'b0;
      end
   end

   always @(posedge o_adc_sck)
   begin
      if (o_adc_cs_n === 1'b0 && fall_cnt >= 3 && fall_cnt <= 5)
         dec_addr = {dec_addr[1:0], o_adc_din};
   end

   // address of this frame is answered in the next one
   always @(posedge o_adc_cs_n)
   begin
      if (fall_cnt == 16)
      begin
         addr_log.push_back(dec_addr);
         ret_ch = dec_addr;
         frame_cnt++;
      end
      fall_cnt = 0;
   end

   always @(negedge clk_50M)
      if (o_node_pulse === 1'b1)
         node_cnt++;

   ////////////////////////////////////////
   // reference, checks and compare
   ////////////////////////////////////////

   function automatic exp_cmd_t ref_motor(input sensor_t s, input exp_cmd_t prev);
      exp_cmd_t r;
      r = prev;
      if (s.centre)
      begin
         r.cmd = '{in_a1: 1'b1, in_a2: 1'b0, in_b1: 1'b1, in_b2: 1'b0};
         r.pwm = '0;
      end
      else if (s.left && !s.right)
      begin
         r.cmd = '{in_a1: 1'b0, in_a2: 1'b0, in_b1: 1'b1, in_b2: 1'b0};
         r.pwm = '{in_a1: 1'b1, in_a2: 1'b0, in_b1: 1'b0, in_b2: 1'b0};
      end
      else if (s.right && !s.left)
      begin
         r.cmd = '{in_a1: 1'b1, in_a2: 1'b0, in_b1: 1'b0, in_b2: 1'b0};
         r.pwm = '{in_a1: 1'b0, in_a2: 1'b0, in_b1: 1'b1, in_b2: 1'b0};
      end
      return r;
   endfunction

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (exp !== act)
      begin
         errors++;
         $display("MISMATCH time=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
      end
   endtask

   always @(negedge clk_50M)
   begin
      if (chk_motor)
      begin
         check_val("o_motor", exp_now.cmd & ~exp_now.pwm, o_motor & ~exp_now.pwm);
         check_val("o_enable_a", 1, o_enable_a);
         check_val("o_enable_b", 1, o_enable_b);
         chk_motor = 0;
      end
      if (chk_hold)
      begin
         check_val("o_motor", 4'hf, o_motor);
         check_val("o_enable_a", 0, o_enable_a);
         check_val("o_enable_b", 0, o_enable_b);
         chk_hold = 0;
      end
   end

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////

   function automatic logic [ADC_BITS-1:0] pick_value(input bit above);
      if (above)
         return ADC_BITS'(THRESHOLD_DEFAULT + 1 + $urandom % (4095 - THRESHOLD_DEFAULT));
      return ADC_BITS'($urandom % (THRESHOLD_DEFAULT + 1));
   endfunction

   function automatic sensor_t to_sensor();
      sensor_t s;
      s.left   = chan_val[CH_LEFT] > THRESHOLD_DEFAULT;
      s.centre = chan_val[CH_CENTRE] > THRESHOLD_DEFAULT;
      s.right  = chan_val[CH_RIGHT] > THRESHOLD_DEFAULT;
      return s;
   endfunction

   task automatic set_pattern(input sensor_t s);
      @(posedge clk_50M);
      #1;
      chan_val[CH_LEFT]   = pick_value(s.left);
      chan_val[CH_CENTRE] = pick_value(s.centre);
      chan_val[CH_RIGHT]  = pick_value(s.right);
   endtask

   task automatic wait_frames(input int n);
      int target;
      target = frame_cnt + n;
      while (frame_cnt < target)
         @(posedge clk_50M);
   endtask

   // wait a full 5-6-7 round with the new values then compare
   task automatic settle_and_compare();
      wait_frames(8);
      repeat (10) @(posedge clk_50M);
      exp_now   = ref_motor(to_sensor(), exp_now);
      chk_motor = 1;
      wait (!chk_motor);
   endtask

   initial
   begin
      void'($urandom(98444));
      i_adc_dout = 1'b0;
      i_hold     = 1'b0;
      dec_addr   = '0;
      ret_ch     = '0;
      exp_now    = '0;
      for (int i = 0; i < 8; i++)
         chan_val[i] = '0;

      @(posedge clk_50M);
      @(negedge clk_50M);
      check_val("o_adc_cs_n", 1, o_adc_cs_n);
      check_val("o_adc_sck", 1, o_adc_sck);
      check_val("o_adc_din", 0, o_adc_din);
      check_val("o_motor", 0, o_motor);
      check_val("o_node_pulse", 0, o_node_pulse);
      wait (!i_rst);

      wait_frames(12);
      for (int i = 0; i < 12; i++)
         check_val("decoded address", 5 + i % 3, addr_log[i]);

      for (int k = 0; k < 8; k++)
      begin
         set_pattern(sensor_t'(3'(k)));
         settle_and_compare();
      end

      // left only so the inner wheel runs on the pwm
      set_pattern('{left: 1'b1, centre: 1'b0, right: 1'b0});
      settle_and_compare();
      for (int w = 0; w < 3; w++)
      begin
         int cnt;
         cnt = 0;
         repeat (PWM_PERIOD)
         begin
            @(negedge clk_50M);
            if (o_motor.in_a1)
               cnt++;
         end
         check_val("in_a1 high count", DUTY_CNT,
                   (cnt >= DUTY_CNT - 1 && cnt <= DUTY_CNT + 1) ? DUTY_CNT : cnt);
      end

      begin
         int f0;
         int f1;
         int f2;
         @(posedge clk_50M);
         #1 i_hold = 1'b1;
         f0 = frame_cnt;
         repeat (2) @(posedge clk_50M);
         chk_hold = 1;
         wait (!chk_hold);
         repeat ((DEPTH + 4) * FRAME_CLKS) @(posedge clk_50M);
         f1 = frame_cnt;
         repeat (2 * FRAME_CLKS) @(posedge clk_50M);
         f2 = frame_cnt;
         check_val("frames stall within limit", 1, (f1 - f0) <= DEPTH + 2);
         check_val("frames while stalled", f1, f2);
         chk_hold = 1;
         wait (!chk_hold);
         @(posedge clk_50M);
         #1 i_hold = 1'b0;
      end
      set_pattern('{left: 1'b0, centre: 1'b0, right: 1'b1});
      wait_frames(1);
      settle_and_compare();

      ////////////////////////////////////////
      // node pulse and hold-off
      ////////////////////////////////////////

      begin
         int n0;
         set_pattern('0);
         wait_frames(8);
         repeat (HOLDOFF + 10) @(posedge clk_50M);
         n0 = node_cnt;
         set_pattern('{left: 1'b0, centre: 1'b1, right: 1'b1});
         while (node_cnt == n0)
            @(posedge clk_50M);
         set_pattern('0);
         repeat (HOLDOFF - 5) @(posedge clk_50M);
         check_val("node pulses in hold-off", n0 + 1, node_cnt);
         wait_frames(8);
         repeat (HOLDOFF) @(posedge clk_50M);
         check_val("node pulses after removal", n0 + 1, node_cnt);
         set_pattern('{left: 1'b0, centre: 1'b1, right: 1'b1});
         while (node_cnt == n0 + 1)
            @(posedge clk_50M);
         repeat (HOLDOFF - 5) @(posedge clk_50M);
         check_val("node pulses after reapply", n0 + 2, node_cnt);
      end

      errors += line_follower_top_inst.adc_serial_reader_inst.asserts_inst.fail_cnt;
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

   // bound by the expected number of frames and hold-off windows
   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog expired before the tests completed, errors so far: %0d", errors);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int HALF_NS    = 10,
   parameter int RST_CYCLES = 2
) (
   output logic clk_50M,
   output logic o_rst
);

   initial
   begin
      clk_50M = 1'b0;
      forever #(HALF_NS) clk_50M = ~clk_50M;
   end

   // reset held over the first rising edges
   initial
   begin
      o_rst = 1'b1;
      repeat (RST_CYCLES) @(posedge clk_50M);
      #1 o_rst = 1'b0;
   end

endmodule
